//--- data_io.f
rtl/data_io_pkg.sv
rtl/spi_file_rx.sv
rtl/word_cdc.sv
rtl/download_ram.sv
rtl/axil_status_port.sv
rtl/data_io_top.sv
sim/data_io_checker.sv
sim/tb_data_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the data_io testbench with Verilator and runs it
# exits with status 0 only when the testbench reports a full pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_data_io -f data_io.f -o tb_data_io
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/tb_data_io)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" <<< "$sim_output"; then
	exit 0
fi

echo "pass message not found in the simulation output"
exit 1

//--- sim/data_io_stimulus.txt
# op test operands, test in decimal, operands in hex
# I idx | O | C | D count w0 w1 w2 w3 | R addr expected stall | X addr data (expects SLVERR)
I 1 15
R 1 000 00000015 0
O 2
R 2 000 00000115 0
R 2 004 00000000 0
D 2 4 1234 abcd 5a5a 0f0f
C 2
R 2 000 00000015 0
R 2 004 00000004 0
R 2 800 00001234 0
R 2 804 0000abcd 0
R 2 808 00005a5a 0
R 2 80c 00000f0f 0
O 3
D 3 2 beef cafe 0 0
C 3
R 3 004 00000002 0
R 3 800 0000beef 0
R 3 804 0000cafe 0
R 3 808 00005a5a 0
R 3 80c 00000f0f 0
D 4 2 dead 1111 0 0
R 4 004 00000002 0
R 4 800 0000beef 0
R 4 804 0000cafe 0
R 5 800 0000beef 1
R 5 804 0000cafe 1
R 5 808 00005a5a 1
R 5 80c 00000f0f 1
R 5 000 00000015 1
R 5 004 00000002 1
X 6 800 ffffffff
X 6 004 00000000
R 6 800 0000beef 0
R 6 004 00000002 0
R 6 100 00000000 0

//--- sim/tb_data_io.sv
// testbench top for the file download channel
// reads operations from the stimulus file, plays SPI frames and AXI
// transactions into the DUT and hands expected values to the checker
// the run is bounded by a cycle limit taken from the stimulus length

module tb_data_io import data_io_pkg::*; ();

	localparam int    RESET_CYCLES = 8;
	localparam int    SCK_HALF     = 4;
	localparam string STIM_FILE    = "sim/data_io_stimulus.txt";

	logic      clk;
	logic      ss;
	logic      sck;
	logic      spi_cs;
	logic      mosi;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	// expected values towards the checker
	logic       push;
	logic       push_write;
	int         push_test;
	uio_cmd_t   push_cmd;
	axil_data_t push_value;
	logic       finish;

	int checks;
	int errors;
	int tests_passed;
	int tests_failed;

	uio_cmd_t last_cmd;
	logic     bad_stim;
	string    lines [$];
	int       cycle_cnt;
	int       cycle_limit;

	data_io_top #(
		.RAM_AW (8)
	) u_data_io_top (
		.clk      (clk),
		.ss       (ss),
		.sck      (sck),
		.spi_cs   (spi_cs),
		.mosi     (mosi),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	data_io_checker u_checker (
		.clk          (clk),
		.ss           (ss),
		.req          (axil_req),
		.rsp          (axil_rsp),
		.push         (push),
		.push_write   (push_write),
		.push_test    (push_test),
		.push_cmd     (push_cmd),
		.push_value   (push_value),
		.finish       (finish),
		.checks       (checks),
		.errors       (errors),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed)
	);

	always #20 clk = ~clk;

	// watchdog, limit is set once the stimulus has been read
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
			$display("run timed out after %0d clk cycles, the DUT stopped answering", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// *************************************************************************
	// drivers
	// *************************************************************************

	// every wait ends 5 units after a rising edge, where inputs change
	task automatic wait_clk(input int n);
		repeat (n) @(posedge clk);
		#5;
	endtask

	// mode 0, msb first, mosi set while sck is low
	task automatic spi_byte(input logic [7:0] value);
		int i;
		for (i = 7; i >= 0; i--) begin
			sck  = 1'b0;
			mosi = value[i];
			wait_clk(SCK_HALF);
			sck = 1'b1;
			wait_clk(SCK_HALF);
		end
	endtask

	// command byte then the low nbytes of payload, highest byte first
	task automatic spi_frame(input uio_cmd_t cmd, input logic [63:0] payload, input int nbytes);
		int i;
		last_cmd = cmd;
		spi_cs   = 1'b0;
		wait_clk(SCK_HALF);
		spi_byte(cmd);
		for (i = nbytes - 1; i >= 0; i--) begin
			spi_byte(payload[i*8 +: 8]);
		end
		sck = 1'b0;
		wait_clk(SCK_HALF);
		spi_cs = 1'b1;
		// room for the last word and the status levels to reach clk
		wait_clk(8);
	endtask

	task automatic expect_response(input logic is_write, input int test, input axil_data_t value);
		push_write = is_write;
		push_test  = test;
		push_cmd   = last_cmd;
		push_value = value;
		push       = 1'b1;
		wait_clk(1);
		push = 1'b0;
	endtask

	// stall holds r_ready low for 0 to 3 cycles once r_valid is up
	task automatic axil_read(input axil_addr_t addr, input logic stall);
		int stall_left;
		stall_left        = stall ? int'($urandom_range(3, 0)) : 0;
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr  = addr;
		axil_req.r_ready  = (stall_left == 0);
		do begin
			@(negedge clk);
		end while (!axil_rsp.ar_ready);
		wait_clk(1);
		axil_req.ar_valid = 1'b0;
		do begin
			@(negedge clk);
		end while (!axil_rsp.r_valid);
		while (stall_left > 0) begin
			wait_clk(1);
			stall_left--;
			axil_req.r_ready = (stall_left == 0);
			@(negedge clk);
		end
		wait_clk(1);
		axil_req.r_ready = 1'b0;
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr  = addr;
		axil_req.w_valid  = 1'b1;
		axil_req.w_data   = data;
		axil_req.b_ready  = 1'b1;
		do begin
			@(negedge clk);
		end while (!axil_rsp.aw_ready);
		wait_clk(1);
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid  = 1'b0;
		do begin
			@(negedge clk);
		end while (!axil_rsp.b_valid);
		wait_clk(1);
		axil_req.b_ready = 1'b0;
	endtask

	// *************************************************************************
	// stimulus
	// *************************************************************************

	task automatic run_line(input string line);
		byte         op;
		int          test;
		int          n;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [63:0] words;
		op = line.getc(0);
		a  = '0;
		b  = '0;
		c  = '0;
		d  = '0;
		e  = '0;
		test = 0;
		void'($sscanf(line.substr(2, line.len() - 1), "%d %h %h %h %h %h", test, a, b, c, d, e));
		n = int'(a);
		case (op)
			"I": spi_frame(UIO_FILE_INDEX, {59'd0, a[4:0]}, 1);
			"O": spi_frame(UIO_FILE_TX, 64'd1, 1);
			"C": spi_frame(UIO_FILE_TX, 64'd0, 1);
			"D": begin
				if ((n < 1) || (n > 4)) begin
					$display("data line needs 1 to 4 words: %s", line);
					bad_stim = 1'b1;
				end else begin
					// first word ends up in the highest used bytes
					words = {b[15:0], c[15:0], d[15:0], e[15:0]};
					spi_frame(UIO_FILE_TX_DAT, words >> (16 * (4 - n)), 2 * n);
				end
			end
			"R": begin
				expect_response(1'b0, test, b);
				axil_read(a[11:0], c[0]);
			end
			"X": begin
				expect_response(1'b1, test, {30'd0, AXIL_SLVERR});
				axil_write(a[11:0], b);
			end
			default: begin
				$display("stimulus line not understood: %s", line);
				bad_stim = 1'b1;
			end
		endcase
	endtask

	initial begin
		int    fd;
		int    i;
		string line;
		clk        = 1'b0;
		ss         = 1'b1;
		sck        = 1'b0;
		spi_cs     = 1'b1;
		mosi       = 1'b0;
		axil_req   = '0;
		push       = 1'b0;
		push_write = 1'b0;
		push_test  = 0;
		push_cmd   = '0;
		push_value = '0;
		finish     = 1'b0;
		last_cmd   = '0;
		bad_stim   = 1'b0;
		void'($urandom(32'h07f54442));
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", STIM_FILE);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// operation lines start with an upper case opcode
				if ((line.len() > 2) && (line.getc(0) >= "A") && (line.getc(0) <= "Z")) begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
			cycle_limit = 400 * lines.size() + 1000;

			wait_clk(RESET_CYCLES);
			ss = 1'b0;
			wait_clk(2);
			for (i = 0; i < lines.size(); i++) begin
				run_line(lines[i]);
			end
			finish = 1'b1;
			wait_clk(2);

			$display("checks %0d, errors %0d, tests passed %0d, tests failed %0d",
				checks, errors, tests_passed, tests_failed);
			if ((errors == 0) && (tests_failed == 0) && !bad_stim && (checks > 0)) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

//--- sim/data_io_checker.sv
// watches the AXI4-Lite side of the DUT and compares every response
// the testbench pushes one expected entry per read or write it issues
// and the entries are matched in order against r and b handshakes
// all sampling is on the falling clk edge where DUT outputs are settled

module data_io_checker import data_io_pkg::*; (
	input  logic       clk,
	input  logic       ss,
	input  axil_req_t  req,
	input  axil_rsp_t  rsp,
	input  logic       push,
	input  logic       push_write,
	input  int         push_test,
	input  uio_cmd_t   push_cmd,
	input  axil_data_t push_value,
	input  logic       finish,
	output int         checks,
	output int         errors,
	output int         tests_passed,
	output int         tests_failed
);

	// expected responses in issue order
	logic       exp_write [$];
	axil_data_t exp_value [$];

	// the running test is closed when the next test number shows up
	int       cur_test = -1;
	int       cur_checks;
	int       cur_errors;
	uio_cmd_t cur_cmd;
	bit       ss_last;
	bit       closed;

	// *************************************************************************
	// helpers
	// *************************************************************************

	// names the last SPI frame before a test for its summary line
	function automatic string cmd_name(input uio_cmd_t cmd);
		case (cmd)
			UIO_FILE_INDEX:  return "menu index";
			UIO_FILE_TX:     return "file open/close";
			UIO_FILE_TX_DAT: return "file data";
			default:         return "no";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		cur_checks++;
		if (actual !== expected) begin
			errors++;
			cur_errors++;
			$display("error at %0t: %s expected 0x%08h, got 0x%08h in test %0d",
				$time, name, expected, actual, cur_test);
		end
	endtask

	task automatic close_test();
		if (cur_test >= 0) begin
			$display("test %0d after %s frame: %0d checks, %0d errors, %s", cur_test,
				cmd_name(cur_cmd), cur_checks, cur_errors,
				(cur_errors == 0) ? "passed" : "failed");
			if (cur_errors == 0) begin
				tests_passed++;
			end else begin
				tests_failed++;
			end
		end
	endtask

	task automatic drop_front();
		void'(exp_write.pop_front());
		void'(exp_value.pop_front());
	endtask

	// *************************************************************************
	// monitor
	// *************************************************************************

	always @(negedge clk) begin
		// control outputs right after reset
		if (ss_last && !ss) begin
			compare("ar_ready", 32'd1, 32'(rsp.ar_ready));
			compare("r_valid", 32'd0, 32'(rsp.r_valid));
			compare("b_valid", 32'd0, 32'(rsp.b_valid));
		end
		ss_last = ss;

		if (!ss && push) begin
			if (push_test != cur_test) begin
				close_test();
				cur_test   = push_test;
				cur_checks = 0;
				cur_errors = 0;
			end
			cur_cmd = push_cmd;
			exp_write.push_back(push_write);
			exp_value.push_back(push_value);
		end

		// write address and write data are accepted together
		if (!ss && req.aw_valid && req.w_valid && rsp.aw_ready) begin
			compare("w_ready", 32'd1, 32'(rsp.w_ready));
		end

		// read handshake completes on the next rising edge
		if (!ss && rsp.r_valid && req.r_ready) begin
			if ((exp_value.size() == 0) || exp_write[0]) begin
				errors++;
				cur_errors++;
				$display("read response at %0t while no read was outstanding", $time);
			end else begin
				compare("r_data", exp_value[0], rsp.r_data);
				compare("r_resp", 32'(AXIL_OKAY), 32'(rsp.r_resp));
				drop_front();
			end
		end

		// for a write the pushed value is the expected b_resp
		if (!ss && rsp.b_valid && req.b_ready) begin
			if ((exp_value.size() == 0) || !exp_write[0]) begin
				errors++;
				cur_errors++;
				$display("write response at %0t while no write was outstanding", $time);
			end else begin
				compare("b_resp", exp_value[0], 32'(rsp.b_resp));
				drop_front();
			end
		end

		if (finish && !closed) begin
			if (exp_value.size() != 0) begin
				errors++;
				$display("%0d expected responses never arrived", exp_value.size());
			end
			close_test();
			closed = 1'b1;
		end
	end

endmodule

//--- rtl/data_io_top.sv
// top of the file download channel
// SPI receiver on sck, toggle CDC into clk, word RAM and AXI4-Lite port
// RAM_AW sets the RAM size and is passed down to the RAM and the port

module data_io_top import data_io_pkg::*; #(
	parameter int RAM_AW = 8
) (
	input  logic      clk,
	input  logic      ss,
	input  logic      sck,
	input  logic      spi_cs,
	input  logic      mosi,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	// sck domain
	logic        downloading;
	menu_index_t index;
	ram_wr_t     rx_word;
	logic        rx_toggle;

	// clk domain
	logic              wr;
	ram_wr_t           wr_word;
	logic              rd_en;
	logic [RAM_AW-1:0] rd_addr;
	file_word_t        rd_data;

	spi_file_rx u_spi_file_rx (
		.sck         (sck),
		.spi_cs      (spi_cs),
		.ss          (ss),
		.mosi        (mosi),
		.downloading (downloading),
		.index       (index),
		.rx_word     (rx_word),
		.rx_toggle   (rx_toggle)
	);

	word_cdc u_word_cdc (
		.clk       (clk),
		.ss        (ss),
		.rx_toggle (rx_toggle),
		.rx_word   (rx_word),
		.wr        (wr),
		.wr_word   (wr_word)
	);

	download_ram #(
		.RAM_AW (RAM_AW)
	) u_download_ram (
		.clk     (clk),
		.wr      (wr),
		.wr_word (wr_word),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	axil_status_port #(
		.RAM_AW (RAM_AW)
	) u_axil_status_port (
		.clk         (clk),
		.ss          (ss),
		.req         (axil_req),
		.downloading (downloading),
		.index       (index),
		.wr          (wr),
		.rd_data     (rd_data),
		.rsp         (axil_rsp),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr)
	);

endmodule

//--- rtl/axil_status_port.sv
// AXI4-Lite slave giving the host read access to the download
// 0x000 status, 0x004 words written since open, 0x800 up RAM words
// one read outstanding at a time, every write answered with SLVERR
// also brings downloading and index over from the sck domain

module axil_status_port import data_io_pkg::*; #(
	parameter int RAM_AW = 8
) (
	input  logic              clk,
	input  logic              ss,
	input  axil_req_t         req,
	input  logic              downloading,
	input  menu_index_t       index,
	input  logic              wr,
	input  file_word_t        rd_data,
	output axil_rsp_t         rsp,
	output logic              rd_en,
	output logic [RAM_AW-1:0] rd_addr
);

	localparam axil_addr_t STATUS_ADDR = 12'h000;
	localparam axil_addr_t COUNT_ADDR  = 12'h004;

	typedef enum logic [1:0] {
		idle,
		wait_ram,
		respond
	} rd_state_t;

	rd_state_t rd_state;

	axil_addr_t rd_addr_q;
	axil_data_t r_data_q;
	logic       b_valid_q;
	logic       ar_hs;
	logic       wr_hs;

	// quasi-static levels from the sck domain
	logic        dl_meta;
	logic        dl_sync;
	logic        dl_last;
	menu_index_t idx_meta;
	menu_index_t idx_sync;

	file_addr_t word_cnt;

	// *************************************************************************
	// status synchronizers and word counter
	// *************************************************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			dl_meta  <= 1'b0;
			dl_sync  <= 1'b0;
			dl_last  <= 1'b0;
			idx_meta <= '0;
			idx_sync <= '0;
			word_cnt <= '0;
		end else begin
			dl_meta  <= downloading;
			dl_sync  <= dl_meta;
			dl_last  <= dl_sync;
			idx_meta <= index;
			idx_sync <= idx_meta;
			// a fresh download restarts the count
			if (dl_sync && !dl_last) begin
				word_cnt <= '0;
			end else if (wr) begin
				word_cnt <= word_cnt + 24'd1;
			end
		end
	end

	// *************************************************************************
	// read path
	// *************************************************************************

	// no new read while either response is still waiting on the host
	assign rsp.ar_ready = (rd_state == idle) && !b_valid_q;
	assign ar_hs        = req.ar_valid && rsp.ar_ready;

	// the RAM read goes out on the handshake itself
	// word slots are 4 bytes apart, the window wraps over the RAM
	assign rd_en   = ar_hs;
	assign rd_addr = req.ar_addr[2 +: RAM_AW];

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			rd_state <= idle;
		end else begin
			case (rd_state)
				idle: if (ar_hs) rd_state <= wait_ram;
				wait_ram: rd_state <= respond;
				respond: if (req.r_ready) rd_state <= idle;
				default: rd_state <= idle;
			endcase
		end
	end

	// address and response data are payload only
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_addr_q <= req.ar_addr;
		end
		// RAM data is ready here, pick the source once and hold it
		if (rd_state == wait_ram) begin
			if (rd_addr_q[11]) begin
				r_data_q <= {16'd0, rd_data};
			end else if (rd_addr_q == STATUS_ADDR) begin
				r_data_q <= {23'd0, dl_sync, 3'd0, idx_sync};
			end else if (rd_addr_q == COUNT_ADDR) begin
				r_data_q <= {8'd0, word_cnt};
			end else begin
				r_data_q <= '0;
			end
		end
	end

	assign rsp.r_valid = (rd_state == respond);
	assign rsp.r_data  = r_data_q;
	assign rsp.r_resp  = AXIL_OKAY;

	// *************************************************************************
	// write path
	// *************************************************************************

	// address and data taken together, contents ignored
	assign wr_hs        = req.aw_valid && req.w_valid && !b_valid_q && (rd_state == idle);
	assign rsp.aw_ready = wr_hs;
	assign rsp.w_ready  = wr_hs;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			b_valid_q <= 1'b0;
		end else if (wr_hs) begin
			b_valid_q <= 1'b1;
		end else if (req.b_ready) begin
			b_valid_q <= 1'b0;
		end
	end

	assign rsp.b_valid = b_valid_q;
	assign rsp.b_resp  = AXIL_SLVERR;

	// a stalled read response must not change under the host
	r_data_hold: assert property (
		@(posedge clk) disable iff (ss)
		rsp.r_valid && !req.r_ready |=> rsp.r_valid && $stable(rsp.r_data)
	) else $error("axil_status_port: r_data changed under back-pressure");

endmodule

//--- rtl/download_ram.sv
// on-chip word RAM holding the downloaded file
// one write port fed by the CDC, one registered read port for the host
// the file address wraps inside the array, only its low RAM_AW bits are used

module download_ram import data_io_pkg::*; #(
	parameter int RAM_AW = 8
) (
	input  logic              clk,
	input  logic              wr,
	input  ram_wr_t           wr_word,
	input  logic              rd_en,
	input  logic [RAM_AW-1:0] rd_addr,
	output file_word_t        rd_data
);

	localparam int RAM_DEPTH = 2 ** RAM_AW;

	// *************************************************************************
	// storage
	// *************************************************************************

	file_word_t mem [RAM_DEPTH];

	// word slot addressed by the low file address bits
	logic [RAM_AW-1:0] wr_slot;

	assign wr_slot = wr_word.addr[RAM_AW-1:0];

	// write port
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_slot] <= wr_word.data;
		end
	end

	// read port
	// data valid the cycle after rd_en, held until the next read
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- rtl/word_cdc.sv
// moves each received word from the sck domain into the clk domain
// the sender flips rx_toggle once per word and holds rx_word stable
// until the next flip, so only the toggle needs a synchronizer
// wr pulses for one clk cycle together with the captured word

module word_cdc import data_io_pkg::*; (
	input  logic    clk,
	input  logic    ss,
	input  logic    rx_toggle,
	input  ram_wr_t rx_word,
	output logic    wr,
	output ram_wr_t wr_word
);

	// two flop synchronizer plus one more stage for the edge detector
	logic tog_meta;
	logic tog_sync;
	logic tog_last;

	// any change of the synchronized toggle is one new word
	logic tog_edge;

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			tog_meta <= 1'b0;
			tog_sync <= 1'b0;
			tog_last <= 1'b0;
		end else begin
			tog_meta <= rx_toggle;
			tog_sync <= tog_meta;
			tog_last <= tog_sync;
		end
	end

	assign tog_edge = tog_sync ^ tog_last;

	// write strobe, 2 to 3 clk after the flip depending on phase
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			wr <= 1'b0;
		end else begin
			wr <= tog_edge;
		end
	end

	// rx_word has been stable for at least two clk by the time the edge shows
	always_ff @(posedge clk) begin
		if (tog_edge) begin
			wr_word <= rx_word;
		end
	end

	// words are 16 sck apart, so two strobes can never touch
	wr_single_cycle: assert property (
		@(posedge clk) disable iff (ss)
		wr |=> !wr
	) else $error("word_cdc: wr high on consecutive cycles");

endmodule

//--- rtl/spi_file_rx.sv
// SPI frame decoder for file downloads from the I/O controller
// runs entirely on sck, mode 0, sampling mosi on the rising edge
// decodes the index, open/close and data commands and hands each
// finished word out with its address, flagged by flipping rx_toggle

module spi_file_rx import data_io_pkg::*; (
	input  logic        sck,
	input  logic        spi_cs,
	input  logic        ss,
	input  logic        mosi,
	output logic        downloading,
	output menu_index_t index,
	output ram_wr_t     rx_word,
	output logic        rx_toggle
);

	// *************************************************************************
	// bit framing
	// *************************************************************************

	// position in the frame
	// 0-7 command, 8-15 first payload byte, 8-23 one data word
	logic [4:0] bit_cnt;

	// the last 15 bits seen, the 16th comes straight from mosi
	logic [14:0] sbuf;

	// command byte of the current frame
	uio_cmd_t cmd;

	// file address of the last word written
	file_addr_t file_addr;
	file_addr_t next_addr;

	logic word_done;

	// spi_cs high aborts the frame and starts over at the command byte
	always_ff @(posedge sck or posedge spi_cs or posedge ss) begin
		if (ss || spi_cs) begin
			bit_cnt <= '0;
		end else if (bit_cnt == 5'd23) begin
			// back to the start of the next word, no new command
			bit_cnt <= 5'd8;
		end else begin
			bit_cnt <= bit_cnt + 5'd1;
		end
	end

	// plain shifter
	always_ff @(posedge sck) begin
		sbuf <= {sbuf[13:0], mosi};
	end

	// *************************************************************************
	// command decode
	// *************************************************************************

	// a word is complete on its last bit, only counted while a download is open
	assign word_done = (bit_cnt == 5'd23) && (cmd == UIO_FILE_TX_DAT) && downloading;
	assign next_addr = file_addr + 24'd1;

	// download state, index, address and toggle outlive spi_cs
	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			cmd         <= '0;
			downloading <= 1'b0;
			index       <= '0;
			file_addr   <= '0;
			rx_toggle   <= 1'b0;
		end else begin
			// finished command byte
			if (bit_cnt == 5'd7) begin
				cmd <= {sbuf[6:0], mosi};
			end

			// open or close, payload bit 0 decides
			if ((cmd == UIO_FILE_TX) && (bit_cnt == 5'd15)) begin
				downloading <= mosi;
				// one below zero so the first word lands at address 0
				if (mosi) begin
					file_addr <= '1;
				end
			end

			// menu index is the low 5 bits of the payload byte
			if ((cmd == UIO_FILE_INDEX) && (bit_cnt == 5'd15)) begin
				index <= {sbuf[3:0], mosi};
			end

			if (word_done) begin
				file_addr <= next_addr;
				rx_toggle <= ~rx_toggle;
			end
		end
	end

	// word and address held until the next toggle, 16 sck periods at least
	always_ff @(posedge sck) begin
		if (word_done) begin
			rx_word.addr <= next_addr;
			rx_word.data <= {sbuf, mosi};
		end
	end

	// counter wraps from 23 to 8 and never runs past the end of a word
	bit_cnt_range: assert property (
		@(posedge sck) disable iff (ss || spi_cs)
		bit_cnt <= 5'd23
	) else $error("spi_file_rx: bit counter out of range");

endmodule

//--- rtl/data_io_pkg.sv
// shared types for the file download channel
// holds the SPI command codes, the word and address widths, the RAM
// write bundle and the AXI4-Lite request and response structs
// every RTL block pulls it in with a wildcard import

package data_io_pkg;

	// widths that carry a meaning
	typedef logic [15:0] file_word_t;
	typedef logic [23:0] file_addr_t;
	typedef logic [4:0]  menu_index_t;
	typedef logic [7:0]  uio_cmd_t;
	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	// command bytes sent by the I/O controller
	localparam uio_cmd_t UIO_FILE_TX     = 8'h53;
	localparam uio_cmd_t UIO_FILE_TX_DAT = 8'h54;
	localparam uio_cmd_t UIO_FILE_INDEX  = 8'h55;

	// AXI response codes
	localparam axil_resp_t AXIL_OKAY   = 2'b00;
	localparam axil_resp_t AXIL_SLVERR = 2'b10;

	// one received word and the file address it belongs to
	typedef struct packed {
		file_addr_t addr;
		file_word_t data;
	} ram_wr_t;

	// host to slave
	typedef struct packed {
		logic       ar_valid;
		axil_addr_t ar_addr;
		logic       aw_valid;
		axil_addr_t aw_addr;
		logic       w_valid;
		axil_data_t w_data;
		logic       r_ready;
		logic       b_ready;
	} axil_req_t;

	// slave to host
	typedef struct packed {
		logic       ar_ready;
		logic       r_valid;
		axil_data_t r_data;
		axil_resp_t r_resp;
		logic       aw_ready;
		logic       w_ready;
		logic       b_valid;
		axil_resp_t b_resp;
	} axil_rsp_t;

endpackage
